// File: spi_ctrl.f
verilog/spi_regs_pkg.sv
verilog/spi_cfg_pkg.sv
verilog/spi_byte_fifo.sv
verilog/spi_shift_engine.sv
verilog/spi_wb_regs.sv
verilog/spi_ctrl_top.sv
verification/spi_slave_model.sv
verification/spi_ctrl_tb.sv

// File: verification/spi_ctrl_tb.sv
/*
 * Testbench of the SPI controller: Wishbone access tasks, a transfer
 * table over all four modes, FIFO limit tests and a watchdog
 */
`timescale 1ns/1ns

module spi_ctrl_tb;
    import spi_regs_pkg::*;
    import spi_cfg_pkg::*;

    localparam int n_rows    = 8;
    localparam int resp_wait = 8;
    localparam int ovf_div   = 1;
    localparam logic [1:0] resp_none = 2'b00;
    localparam logic [1:0] resp_ack  = 2'b01;
    localparam logic [1:0] resp_err  = 2'b10;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [wb_addr_w-1:0] adr;
    logic [wb_data_w-1:0] dat_w;
    logic [wb_data_w-1:0] dat_r;
    logic                 ack;
    logic                 err;
    logic                 sclk;
    logic                 mosi;
    logic                 miso;
    logic [cs_w-1:0]      chip_select;
    logic                 slave_rst;
    logic                 cur_cpol;
    logic                 cur_cpha;

    // Transfer table, mode bits laid out as in the configuration register
    logic [conf_w-1:0] row_mode [n_rows];
    logic [div_w-1:0]  row_div  [n_rows];
    spi_byte_t         row_tx   [n_rows];
    spi_byte_t         row_exp  [n_rows];
    logic              table_loaded;

    integer seed;
    int     tests_run;
    int     tests_failed;
    int     errors;
    int     test_errors;

    spi_ctrl_top u_dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .miso(miso), .dat_r(dat_r), .ack(ack), .err(err), .sclk(sclk), .mosi(mosi),
        .chip_select(chip_select)
    );

    spi_slave_model u_slave (
        .clk(clk), .rst(slave_rst), .sclk(sclk), .mosi(mosi),
        .cpol(cur_cpol), .cpha(cur_cpha), .miso(miso)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Reporting
    ////////////////////

    task automatic note_error(input string msg);
        $display("error: %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic string resp_name(input logic [1:0] resp);
        case (resp)
            resp_ack:  return "ack";
            resp_err:  return "err";
            resp_none: return "nothing";
            default:   return "ack and err";
        endcase
    endfunction

    function automatic logic [wb_data_w-1:0] width_mask(input int w);
        return (w >= wb_data_w) ? '1 : ((wb_data_w'(1) << w) - 1'b1);
    endfunction

    ////////////////////
    // Bus and reset tasks
    ////////////////////

    // One classic cycle, stb dropped on the edge after the response
    task automatic bus_access(input logic write, input logic [reg_offset_w-1:0] offset,
                              input logic [wb_data_w-1:0] wdata,
                              output logic [wb_data_w-1:0] rdata, output logic [1:0] resp);
        int waited;
        @(posedge clk);
        #10;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = wb_addr_w'(offset);
        dat_w = wdata;
        resp  = resp_none;
        rdata = '0;
        waited = 0;
        while (resp == resp_none && waited < resp_wait)
        begin
            @(negedge clk);
            waited++;
            if (ack || err)
            begin
                resp  = {err, ack};
                rdata = dat_r;
            end
        end
        @(posedge clk);
        #10;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (resp == resp_none)
            note_failure($sformatf("no bus response at %0t ns, offset %h", $time, offset));
    endtask

    task automatic write_reg(input logic [reg_offset_w-1:0] offset,
                             input logic [wb_data_w-1:0] data, input logic [1:0] exp_resp);
        logic [wb_data_w-1:0] unused;
        logic [1:0]           resp;
        bus_access(1'b1, offset, data, unused, resp);
        if (resp != resp_none && resp != exp_resp)
            note_error($sformatf("write to %h got %s, expected %s", offset,
                                 resp_name(resp), resp_name(exp_resp)));
    endtask

    task automatic read_check(input logic [reg_offset_w-1:0] offset,
                              input logic [wb_data_w-1:0] exp_data, input logic [1:0] exp_resp);
        logic [wb_data_w-1:0] rdata;
        logic [1:0]           resp;
        bus_access(1'b0, offset, '0, rdata, resp);
        if (resp != resp_none && resp != exp_resp)
            note_error($sformatf("read of %h got %s, expected %s", offset,
                                 resp_name(resp), resp_name(exp_resp)));
        else if (resp == resp_ack && rdata !== exp_data)
            note_error($sformatf("read of %h returned %h, expected %h", offset,
                                 rdata, exp_data));
    endtask

    task automatic wait_count(input logic [reg_offset_w-1:0] offset, input int target,
                              input int max_polls);
        logic [wb_data_w-1:0] rdata;
        logic [1:0]           resp;
        int                   polls;
        logic                 reached;
        reached = 1'b0;
        polls   = 0;
        while (!reached && polls < max_polls)
        begin
            bus_access(1'b0, offset, '0, rdata, resp);
            polls++;
            if (resp == resp_ack && rdata == target)
                reached = 1'b1;
        end
        if (!reached)
            note_failure($sformatf("count at offset %h never reached %0d", offset, target));
    endtask

    task automatic reset_dut();
        rst       = 1'b1;
        slave_rst = 1'b1;
        cur_cpol  = 1'b0;
        cur_cpha  = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst       = 1'b0;
        slave_rst = 1'b0;
    endtask

    // Clears the slave after SCLK settles at a new idle level
    task automatic reset_slave();
        @(posedge clk);
        #10;
        slave_rst = 1'b1;
        @(posedge clk);
        #10;
        slave_rst = 1'b0;
    endtask

    task automatic set_row(input int i, input logic [conf_w-1:0] mode,
                           input logic [div_w-1:0] div, input spi_byte_t tx,
                           input spi_byte_t exp);
        row_mode[i] = mode;
        row_div[i]  = div;
        row_tx[i]   = tx;
        row_exp[i]  = exp;
    endtask

    // Slave echoes the previous byte, zero right after its reset
    task automatic load_table();
        set_row(0, 2'd0, 16'd0, 8'ha5, 8'h00);
        set_row(1, 2'd0, 16'd3, 8'h3c, 8'ha5);
        set_row(2, 2'd1, 16'd1, 8'h96, 8'h00);
        set_row(3, 2'd1, 16'd2, 8'h5a, 8'h96);
        set_row(4, 2'd2, 16'd0, 8'hc3, 8'h00);
        set_row(5, 2'd2, 16'd4, 8'h0f, 8'hc3);
        set_row(6, 2'd3, 16'd1, 8'hf0, 8'h00);
        set_row(7, 2'd3, 16'd2, 8'h81, 8'hf0);
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    initial
    begin : watchdog
        longint limit_ns;
        int     max_div;
        wait (table_loaded === 1'b1);
        max_div = 0;
        for (int i = 0; i < n_rows; i++)
            if (row_div[i] > max_div)
                max_div = row_div[i];
        limit_ns = longint'(n_rows) * (2 * bits_per_xfer) * (max_div + 1) * 100 * 4 + 100_000;
        #(limit_ns);
        $display("watchdog timeout, tests still running after %0d ns", limit_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        logic [conf_w-1:0] prev_mode;
        logic              mode_valid;
        spi_byte_t         fill [10];
        clk          = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        test_errors  = 0;
        seed         = 32'ha5544d3a;
        table_loaded = 1'b0;
        load_table();
        table_loaded = 1'b1;
        reset_dut();

        // Register map
        read_check(addr_cs, width_mask(cs_w), resp_ack);
        if (chip_select !== '1)
            note_error($sformatf("chip_select is %h after reset", chip_select));
        write_reg(addr_conf, 32'hffff_ffff, resp_ack);
        read_check(addr_conf, 32'hffff_ffff & width_mask(conf_w), resp_ack);
        write_reg(addr_div, 32'hdead_1234, resp_ack);
        read_check(addr_div, 32'hdead_1234 & width_mask(div_w), resp_ack);
        write_reg(addr_cs, 32'hffff_ff5a, resp_ack);
        read_check(addr_cs, 32'hffff_ff5a & width_mask(cs_w), resp_ack);
        if (chip_select !== 8'h5a)
            note_error($sformatf("chip_select is %h, expected 5a", chip_select));
        read_check(8'h0c, '0, resp_ack);
        write_reg(addr_rx_count, 32'h5, resp_ack);
        read_check(addr_rx_count, '0, resp_ack);
        write_reg(addr_conf, '0, resp_ack);
        write_reg(addr_div, '0, resp_ack);
        finish_test("registers");

        // One transfer per row, slave cleared on each mode change
        mode_valid = 1'b0;
        prev_mode  = '0;
        for (int i = 0; i < n_rows; i++)
        begin
            if (!mode_valid || row_mode[i] != prev_mode)
            begin
                write_reg(addr_conf, wb_data_w'(row_mode[i]), resp_ack);
                cur_cpol = row_mode[i][conf_cpol_bit];
                cur_cpha = row_mode[i][conf_cpha_bit];
                reset_slave();
            end
            prev_mode  = row_mode[i];
            mode_valid = 1'b1;
            write_reg(addr_div, wb_data_w'(row_div[i]), resp_ack);
            write_reg(addr_data, wb_data_w'(row_tx[i]), resp_ack);
            wait_count(addr_rx_count, 1, 2 * bits_per_xfer * (row_div[i] + 1) + 8);
            if (sclk !== cur_cpol)
                note_error($sformatf("sclk is %b when idle, cpol is %b", sclk, cur_cpol));
            read_check(addr_data, wb_data_w'(row_exp[i]), resp_ack);
            finish_test($sformatf("transfer row %0d", i));
        end

        read_check(addr_data, '0, resp_err);
        read_check(addr_rx_count, '0, resp_ack);
        finish_test("rx empty");

        // Slowest divider keeps the first byte in the engine
        write_reg(addr_div, width_mask(div_w), resp_ack);
        for (int k = 0; k < 10; k++)
        begin
            fill[k] = $random(seed);
            write_reg(addr_data, wb_data_w'(fill[k]), (k <= fifo_depth) ? resp_ack : resp_err);
        end
        read_check(addr_tx_count, wb_data_w'(fifo_depth), resp_ack);
        finish_test("tx full");
        reset_dut();

        // Ten transfers into an RX FIFO of eight, no reads in between
        write_reg(addr_div, wb_data_w'(ovf_div), resp_ack);
        for (int k = 0; k < 10; k++)
        begin
            fill[k] = $random(seed);
            write_reg(addr_data, wb_data_w'(fill[k]), resp_ack);
            wait_count(addr_tx_count, 0, 2 * bits_per_xfer * (ovf_div + 1) + 8);
        end
        // Last transfer: load, 16 edges, then the push
        repeat (2 * bits_per_xfer * (ovf_div + 1) + 4) @(posedge clk);
        #10;
        read_check(addr_rx_count, wb_data_w'(fifo_depth), resp_ack);
        read_check(addr_data, '0, resp_ack);
        for (int k = 0; k < fifo_depth - 1; k++)
            read_check(addr_data, wb_data_w'(fill[k]), resp_ack);
        read_check(addr_data, '0, resp_err);
        finish_test("rx overflow");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/spi_slave_model.sv
/*
 * Behavioral SPI slave for all four cpol/cpha modes, returns
 * the byte received in the previous transfer
 */
`timescale 1ns/1ns

module spi_slave_model (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic cpol,
    input  logic cpha,
    output logic miso
);
    import spi_cfg_pkg::*;

    spi_byte_t shift_reg;
    logic      sclk_q;
    logic      mosi_bit;
    logic      sclk_edge;
    logic      sample_edge;

    // SCLK looked at on the falling clk edge, half a cycle after the engine moves it
    assign sclk_edge   = (sclk != sclk_q);
    // Rising SCLK samples when cpol equals cpha
    assign sample_edge = sclk_edge && (sclk == (cpol == cpha));
    assign miso        = shift_reg[$bits(spi_byte_t)-1];

    always_ff @(negedge clk)
    begin
        if (rst)
        begin
            shift_reg <= '0;
            sclk_q    <= sclk;
            mosi_bit  <= 1'b0;
        end
        else
        begin
            sclk_q <= sclk;
            if (sample_edge && cpha)
            begin
                shift_reg <= {shift_reg[$bits(spi_byte_t)-2:0], mosi};
            end
            else if (sample_edge)
            begin
                mosi_bit <= mosi;
            end
            else if (sclk_edge && !cpha)
            begin
                // cpha 0 shifts the held bit in on the trailing edge
                shift_reg <= {shift_reg[$bits(spi_byte_t)-2:0], mosi_bit};
            end
        end
    end

endmodule

// File: verilog/spi_byte_fifo.sv
/*
 * Synchronous show-ahead byte FIFO with occupancy count
 */
`timescale 1ns/1ns

module spi_byte_fifo (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 push,
    input  spi_cfg_pkg::spi_byte_t               push_data,
    input  logic                                 pop,
    output spi_cfg_pkg::spi_byte_t               head,
    output logic                                 full,
    output logic                                 empty,
    output logic [spi_cfg_pkg::fifo_count_w-1:0] count
);
    import spi_cfg_pkg::*;

    spi_byte_t             mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign full  = (count == fifo_count_w'(fifo_depth));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // A pop frees the slot, so a full FIFO still takes a push
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: verilog/spi_cfg_pkg.sv
/*
 * Data path sizing of the SPI controller: byte type,
 * FIFO depth and widths, divider width
 */
package spi_cfg_pkg;

    typedef logic [7:0] spi_byte_t;

    ////////////////////
    // FIFO sizing
    ////////////////////

    localparam int fifo_depth   = 8;
    localparam int fifo_ptr_w   = 3;
    // Holds 0 up to fifo_depth
    localparam int fifo_count_w = 4;

    ////////////////////
    // Shift engine
    ////////////////////

    localparam int div_w         = 16;
    localparam int bits_per_xfer = 8;

endpackage

// File: verilog/spi_ctrl_top.sv
/*
 * SPI controller top: Wishbone register block, TX and RX byte FIFOs
 * and the shift engine
 */
`timescale 1ns/1ns

module spi_ctrl_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [spi_regs_pkg::wb_addr_w-1:0] adr,
    input  logic [spi_regs_pkg::wb_data_w-1:0] dat_w,
    input  logic                               miso,
    output logic [spi_regs_pkg::wb_data_w-1:0] dat_r,
    output logic                               ack,
    output logic                               err,
    output logic                               sclk,
    output logic                               mosi,
    output logic [spi_regs_pkg::cs_w-1:0]      chip_select
);
    import spi_cfg_pkg::*;

    ////////////////////
    // TX path
    ////////////////////

    logic                    tx_push;
    spi_byte_t               tx_push_data;
    logic                    tx_pop;
    spi_byte_t               tx_head;
    logic                    tx_full;
    logic                    tx_empty;
    logic [fifo_count_w-1:0] tx_count;

    ////////////////////
    // RX path
    ////////////////////

    logic                    rx_push;
    spi_byte_t               rx_push_data;
    logic                    rx_pop;
    spi_byte_t               rx_head;
    logic                    rx_empty;
    logic [fifo_count_w-1:0] rx_count;

    // Engine configuration
    logic             cpol;
    logic             cpha;
    logic [div_w-1:0] divider;

    spi_wb_regs u_regs (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .tx_full(tx_full), .tx_count(tx_count), .rx_count(rx_count),
        .rx_empty(rx_empty), .rx_head(rx_head), .dat_r(dat_r), .ack(ack), .err(err),
        .tx_push(tx_push), .tx_push_data(tx_push_data), .rx_pop(rx_pop),
        .cpol(cpol), .cpha(cpha), .divider(divider), .chip_select(chip_select)
    );

    spi_byte_fifo u_tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_push_data), .pop(tx_pop),
        .head(tx_head), .full(tx_full), .empty(tx_empty), .count(tx_count)
    );

    // Overflow bytes are dropped inside the FIFO, full flag unused
    spi_byte_fifo u_rx_fifo (
        .clk(clk), .rst(rst), .push(rx_push), .push_data(rx_push_data), .pop(rx_pop),
        .head(rx_head), .full(), .empty(rx_empty), .count(rx_count)
    );

    spi_shift_engine u_engine (
        .clk(clk), .rst(rst), .cpol(cpol), .cpha(cpha), .divider(divider),
        .tx_empty(tx_empty), .tx_head(tx_head), .miso(miso), .tx_pop(tx_pop),
        .rx_push(rx_push), .rx_push_data(rx_push_data), .sclk(sclk), .mosi(mosi)
    );

endmodule

// File: verilog/spi_regs_pkg.sv
/*
 * Register map of the SPI controller: Wishbone widths,
 * byte offsets of the registers and configuration bit positions
 */
package spi_regs_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int wb_data_w = 32;
    localparam int wb_addr_w = 32;

    // Low address bits seen by the decoder
    localparam int reg_offset_w = 8;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam logic [reg_offset_w-1:0] addr_data     = 8'h00;
    localparam logic [reg_offset_w-1:0] addr_conf     = 8'h04;
    localparam logic [reg_offset_w-1:0] addr_div      = 8'h08;
    localparam logic [reg_offset_w-1:0] addr_cs       = 8'h10;
    localparam logic [reg_offset_w-1:0] addr_rx_count = 8'h18;
    localparam logic [reg_offset_w-1:0] addr_tx_count = 8'h1C;

    ////////////////////
    // Configuration register
    ////////////////////

    localparam int conf_w        = 2;
    // Clock idle level
    localparam int conf_cpol_bit = 0;
    // Clock phase, 1 shifts on the leading edge
    localparam int conf_cpha_bit = 1;

    // Chip-select lines
    localparam int cs_w = 8;

endpackage

// File: verilog/spi_shift_engine.sv
/*
 * SPI shift engine: clock divider, SCLK generation in all four
 * cpol/cpha modes and the MOSI/MISO shift register, one byte per transfer
 */
`timescale 1ns/1ns

module spi_shift_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cpol,
    input  logic                          cpha,
    input  logic [spi_cfg_pkg::div_w-1:0] divider,
    input  logic                          tx_empty,
    input  spi_cfg_pkg::spi_byte_t        tx_head,
    input  logic                          miso,
    output logic                          tx_pop,
    output logic                          rx_push,
    output spi_cfg_pkg::spi_byte_t        rx_push_data,
    output logic                          sclk,
    output logic                          mosi
);
    import spi_cfg_pkg::*;

    localparam int edge_cnt_w = $clog2(2 * bits_per_xfer);
    localparam logic [edge_cnt_w-1:0] last_edge = edge_cnt_w'(2 * bits_per_xfer - 1);

    typedef enum logic [1:0] {st_idle, st_load, st_shift, st_finish} eng_state_t;

    eng_state_t            state;
    logic [div_w-1:0]      div_cnt;
    logic [edge_cnt_w-1:0] edge_cnt;
    spi_byte_t             shift_reg;
    logic                  rx_bit;
    logic                  edge_tick;
    logic                  leading;
    logic                  sample_now;
    logic                  shift_now;

    // SCLK toggles once the divider count is reached
    assign edge_tick = (state == st_shift) && (div_cnt == divider);
    // Even edge count is a leading edge
    assign leading   = ~edge_cnt[0];

    // cpha 0 samples on leading edges, cpha 1 on trailing ones
    assign sample_now = edge_tick && (cpha ? !leading : leading);

    // First and last shifts are folded into load and finish
    assign shift_now = edge_tick && (cpha ? leading : !leading)
                       && (edge_cnt != '0) && (edge_cnt != last_edge);

    assign tx_pop       = (state == st_idle) && !tx_empty;
    assign rx_push      = (state == st_finish);
    assign rx_push_data = {shift_reg[$bits(spi_byte_t)-2:0], rx_bit};
    assign mosi         = shift_reg[$bits(spi_byte_t)-1];

    ////////////////////
    // Transfer FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            sclk      <= 1'b0;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            shift_reg <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    sclk <= cpol;
                    if (!tx_empty)
                    begin
                        shift_reg <= tx_head;
                        state     <= st_load;
                    end
                end
                // MSB already on MOSI, counters cleared
                st_load:
                begin
                    sclk     <= cpol;
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    state    <= st_shift;
                end
                st_shift:
                begin
                    if (edge_tick)
                    begin
                        sclk     <= ~sclk;
                        div_cnt  <= '0;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (edge_cnt == last_edge)
                        begin
                            state <= st_finish;
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (shift_now)
                    begin
                        shift_reg <= {shift_reg[$bits(spi_byte_t)-2:0], rx_bit};
                    end
                end
                // Received byte goes to the RX FIFO here
                st_finish:
                begin
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // MISO sample, held until the next shift
    always_ff @(posedge clk)
    begin
        if (sample_now)
        begin
            rx_bit <= miso;
        end
    end

endmodule

// File: verilog/spi_wb_regs.sv
/*
 * Wishbone classic slave of the SPI controller: address decode,
 * single-cycle ack/err response, configuration, divider and chip-select registers
 */
`timescale 1ns/1ns

module spi_wb_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [spi_regs_pkg::wb_addr_w-1:0]   adr,
    input  logic [spi_regs_pkg::wb_data_w-1:0]   dat_w,
    input  logic                                 tx_full,
    input  logic [spi_cfg_pkg::fifo_count_w-1:0] tx_count,
    input  logic [spi_cfg_pkg::fifo_count_w-1:0] rx_count,
    input  logic                                 rx_empty,
    input  spi_cfg_pkg::spi_byte_t               rx_head,
    output logic [spi_regs_pkg::wb_data_w-1:0]   dat_r,
    output logic                                 ack,
    output logic                                 err,
    output logic                                 tx_push,
    output spi_cfg_pkg::spi_byte_t               tx_push_data,
    output logic                                 rx_pop,
    output logic                                 cpol,
    output logic                                 cpha,
    output logic [spi_cfg_pkg::div_w-1:0]        divider,
    output logic [spi_regs_pkg::cs_w-1:0]        chip_select
);
    import spi_regs_pkg::*;
    import spi_cfg_pkg::*;

    typedef enum logic {st_idle, st_respond} bus_state_t;

    bus_state_t              state;
    logic [reg_offset_w-1:0] offset;
    logic [conf_w-1:0]       conf_reg;
    logic [wb_data_w-1:0]    rd_data;
    logic                    take_req;
    logic                    reject;

    assign offset   = adr[reg_offset_w-1:0];
    assign take_req = (state == st_idle) && cyc && stb;

    // Data access fails on a full TX FIFO or an empty RX FIFO
    assign reject = (offset == addr_data) && (we ? tx_full : rx_empty);

    assign cpol = conf_reg[conf_cpol_bit];
    assign cpha = conf_reg[conf_cpha_bit];

    ////////////////////
    // Read data mux
    ////////////////////

    always_comb
    begin
        case (offset)
            addr_data:     rd_data = {{(wb_data_w-$bits(spi_byte_t)){1'b0}}, rx_head};
            addr_conf:     rd_data = {{(wb_data_w-conf_w){1'b0}}, conf_reg};
            addr_div:      rd_data = {{(wb_data_w-div_w){1'b0}}, divider};
            addr_cs:       rd_data = {{(wb_data_w-cs_w){1'b0}}, chip_select};
            addr_rx_count: rd_data = {{(wb_data_w-fifo_count_w){1'b0}}, rx_count};
            addr_tx_count: rd_data = {{(wb_data_w-fifo_count_w){1'b0}}, tx_count};
            default:       rd_data = '0;
        endcase
    end

    ////////////////////
    // Bus FSM and control registers
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            ack         <= 1'b0;
            err         <= 1'b0;
            tx_push     <= 1'b0;
            rx_pop      <= 1'b0;
            conf_reg    <= '0;
            divider     <= '0;
            chip_select <= '1;
        end
        else
        begin
            // Responses and FIFO strobes last a single cycle
            ack     <= 1'b0;
            err     <= 1'b0;
            tx_push <= 1'b0;
            rx_pop  <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (take_req)
                    begin
                        state <= st_respond;
                        if (reject)
                        begin
                            err <= 1'b1;
                        end
                        else
                        begin
                            ack <= 1'b1;
                            if (we)
                            begin
                                // Count registers and unmapped offsets ignore writes
                                case (offset)
                                    addr_data: tx_push     <= 1'b1;
                                    addr_conf: conf_reg    <= dat_w[conf_w-1:0];
                                    addr_div:  divider     <= dat_w[div_w-1:0];
                                    addr_cs:   chip_select <= dat_w[cs_w-1:0];
                                    default:   ;
                                endcase
                            end
                            else if (offset == addr_data)
                            begin
                                rx_pop <= 1'b1;
                            end
                        end
                    end
                end
                // Recovery cycle, no request taken
                st_respond:
                begin
                    state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Response data and the byte to push
    always_ff @(posedge clk)
    begin
        if (take_req)
        begin
            dat_r        <= rd_data;
            tx_push_data <= dat_w[$bits(spi_byte_t)-1:0];
        end
    end

endmodule
